// File: verilog/aesPkg.sv
`default_nettype none

package aesPkg;

  // AES-128 sizes
  localparam int BlockBits = 128;
  localparam int KeyBits = 128;
  localparam int NumRounds = 10;

  // First round constant and the GF(2^8) reduction term
  localparam logic [7:0] RconInit = 8'h01;
  localparam logic [7:0] ReducePoly = 8'h1b;

  typedef logic [7:0] byteT;

  // Key schedule word or one state column
  typedef logic [31:0] wordT;

  // Byte 0 sits in the top bits, column-major as in FIPS-197
  typedef logic [BlockBits-1:0] stateT;

  typedef struct packed {
    stateT plainText;
    logic [KeyBits-1:0] cipherKey;
  } aesReqT;

  typedef logic [3:0] roundCountT;

  // Multiply by x modulo the AES polynomial
  function automatic byteT xtime(byteT b);
    byteT shifted;
    shifted = {b[6:0], 1'b0};
    if (b[7])
    begin
      shifted = shifted ^ ReducePoly;
    end
    return shifted;
  endfunction

endpackage

`default_nettype wire

// File: verilog/aesSbox.sv
`timescale 1ns/10ps
`default_nettype none

module aesSbox
  import aesPkg::*;
(
  input  byteT dataIn,
  output byteT dataOut
);

  // Forward substitution, index 0 first
  byteT sboxTable [256];

  assign sboxTable = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  assign dataOut = sboxTable[dataIn];

endmodule

`default_nettype wire

// File: verilog/aesMixColumns.sv
`timescale 1ns/10ps
`default_nettype none

module aesMixColumns
  import aesPkg::*;
(
  input  stateT stateIn,
  output stateT stateOut
);

  genvar c;
  genvar r;

  for (c = 0; c < 4; c++)
  begin : gCol
    // Bytes of one column, row 0 first
    byteT a [4];

    for (r = 0; r < 4; r++)
    begin : gSplit
      assign a[r] = stateIn[BlockBits-1-32*c-8*r -: 8];
    end

    // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
    for (r = 0; r < 4; r++)
    begin : gMix
      assign stateOut[BlockBits-1-32*c-8*r -: 8] = xtime(a[r])
                                                  ^ xtime(a[(r+1)%4])
                                                  ^ a[(r+1)%4]
                                                  ^ a[(r+2)%4]
                                                  ^ a[(r+3)%4];
    end
  end

endmodule

`default_nettype wire

// File: verilog/aesRound.sv
`timescale 1ns/10ps
`default_nettype none

module aesRound
  import aesPkg::*;
(
  input  stateT stateIn,
  input  stateT roundKey,
  input  logic  finalRound,
  output stateT stateOut
);

  stateT subState;
  stateT shiftState;
  stateT mixState;

  genvar i;
  genvar c;
  genvar r;

  // SubBytes
  for (i = 0; i < 16; i++)
  begin : gSbox
    aesSbox uSbox (
      .dataIn (stateIn[BlockBits-1-8*i -: 8]),
      .dataOut(subState[BlockBits-1-8*i -: 8])
    );
  end

  // ShiftRows, row r rotated left by r columns
  for (c = 0; c < 4; c++)
  begin : gShiftCol
    for (r = 0; r < 4; r++)
    begin : gShiftRow
      assign shiftState[BlockBits-1-8*(4*c+r) -: 8] =
        subState[BlockBits-1-8*(4*((c+r)%4)+r) -: 8];
    end
  end

  aesMixColumns uMix (
    .stateIn (shiftState),
    .stateOut(mixState)
  );

  // Last round skips MixColumns
  assign stateOut = (finalRound ? shiftState : mixState) ^ roundKey;

endmodule

`default_nettype wire

// File: verilog/aesKeyExpand.sv
`timescale 1ns/10ps
`default_nettype none

module aesKeyExpand
  import aesPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  logic  load,
  input  logic  advance,
  input  stateT cipherKey,
  output stateT roundKey
);

  stateT keyReg;
  byteT rcon;

  wordT lastWord;
  wordT rotWord;
  wordT subWord;
  wordT tempWord;
  wordT key0;
  wordT key1;
  wordT key2;
  wordT key3;

  assign lastWord = keyReg[31:0];
  assign rotWord = {lastWord[23:0], lastWord[31:24]};

  for (genvar i = 0; i < 4; i++)
  begin : gSubWord
    aesSbox uSbox (
      .dataIn (rotWord[8*i +: 8]),
      .dataOut(subWord[8*i +: 8])
    );
  end

  assign tempWord = subWord ^ {rcon, 24'h000000};

  // Each word chains off the one before it
  assign key0 = keyReg[127:96] ^ tempWord;
  assign key1 = keyReg[95:64] ^ key0;
  assign key2 = keyReg[63:32] ^ key1;
  assign key3 = lastWord ^ key2;

  assign roundKey = {key0, key1, key2, key3};

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      rcon <= RconInit;
    else if (load)
      rcon <= RconInit;
    else if (advance)
      rcon <= xtime(rcon);
  end

  always_ff @(posedge clk)
  begin
    if (load)
      keyReg <= cipherKey;
    else if (advance)
      keyReg <= roundKey;
  end

endmodule

`default_nettype wire

// File: verilog/aesCore.sv
`timescale 1ns/10ps
`default_nettype none

module aesCore
  import aesPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  logic   inValid,
  output logic   inReady,
  input  aesReqT inReq,
  output logic   outValid,
  input  logic   outReady,
  output stateT  outData
);

  typedef enum logic [1:0] {
    Idle,
    Busy,
    Done
  } fsmT;

  fsmT fsm;
  roundCountT roundCnt;

  stateT stateReg;
  stateT roundOut;
  stateT roundKey;

  logic accept;
  logic load;
  logic advance;
  logic finalRound;

  assign accept = inValid && inReady;
  assign load = accept;
  assign advance = (fsm == Busy);
  assign finalRound = (roundCnt == roundCountT'(NumRounds));

  assign inReady = (fsm == Idle);
  assign outValid = (fsm == Done);
  assign outData = stateReg;

  aesKeyExpand uKeyExpand (
    .clk      (clk),
    .rstN     (rstN),
    .load     (load),
    .advance  (advance),
    .cipherKey(inReq.cipherKey),
    .roundKey (roundKey)
  );

  aesRound uRound (
    .stateIn   (stateReg),
    .roundKey  (roundKey),
    .finalRound(finalRound),
    .stateOut  (roundOut)
  );

  // Round counter names the round being computed this cycle
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      fsm <= Idle;
      roundCnt <= '0;
    end
    else
    begin
      case (fsm)
        Idle:
        begin
          if (accept)
          begin
            fsm <= Busy;
            roundCnt <= roundCountT'(1);
          end
        end
        Busy:
        begin
          if (finalRound)
            fsm <= Done;
          else
            roundCnt <= roundCnt + roundCountT'(1);
        end
        Done:
        begin
          if (outReady)
            fsm <= Idle;
        end
        default:
          fsm <= Idle;
      endcase
    end
  end

  // Initial AddRoundKey on accept, then one round per busy cycle
  always_ff @(posedge clk)
  begin
    if (accept)
      stateReg <= inReq.plainText ^ inReq.cipherKey;
    else if (advance)
      stateReg <= roundOut;
  end

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
  output logic clk
);

  // 10 ns period
  localparam int HalfPeriodNs = 5;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(HalfPeriodNs) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tbAesCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbAesCore
  import aesPkg::*;
();

  localparam int ClockNs = 10;
  localparam int ResetCycles = 5;
  localparam int AcceptLimit = 40;
  localparam int ResultLimit = 40;
  localparam int HoldCycles = 20;

  // Per test: reset, ten rounds and a back-pressure margin
  localparam int NumTests = 6;
  localparam int CyclesPerTest = ResetCycles + NumRounds + 30;
  localparam int TimeoutNs = NumTests * CyclesPerTest * ClockNs + 1000;

  // Published AES-128 vectors
  localparam stateT PlainB = 128'h3243f6a8885a308d313198a2e0370734;
  localparam stateT KeyB = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam stateT CipherB = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam stateT PlainC1 = 128'h00112233445566778899aabbccddeeff;
  localparam stateT KeyC1 = 128'h000102030405060708090a0b0c0d0e0f;
  localparam stateT CipherC1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam stateT CipherZero = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

  logic clk;
  logic rstN;
  logic inValid;
  logic inReady;
  aesReqT inReq;
  logic outValid;
  logic outReady;
  stateT outData;

  int errorCount = 0;
  int checkCount = 0;

  tbClock uClock (
    .clk(clk)
  );

  aesCore u_dut (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inReady (inReady),
    .inReq   (inReq),
    .outValid(outValid),
    .outReady(outReady),
    .outData (outData)
  );

  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  // Returns on the accept edge
  task automatic waitAccept();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!inReady && waited < AcceptLimit)
    begin
      @(negedge clk);
      waited++;
    end
    if (!inReady)
    begin
      $display("Error at %0t ns: request not accepted within %0d cycles", $time, AcceptLimit);
      errorCount++;
    end
    @(posedge clk);
  endtask

  // Counts edges from the accept edge until outValid is seen
  task automatic waitResult(output int cycles);
    logic finished;
    cycles = 0;
    finished = 1'b0;
    while (!finished)
    begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (outValid)
        finished = 1'b1;
      else
      begin
        checkValue("inReady", 128'd0, 128'(inReady));
        if (cycles >= ResultLimit)
        begin
          $display("Error at %0t ns: no result within %0d cycles", $time, ResultLimit);
          errorCount++;
          finished = 1'b1;
        end
      end
    end
    checkValue("inReady", 128'd0, 128'(inReady));
  endtask

  task automatic testReset();
    @(negedge clk);
    checkValue("outValid", 128'd0, 128'(outValid));
    checkValue("inReady", 128'd1, 128'(inReady));
  endtask

  task automatic encryptBlock(input stateT plain, input stateT key, input stateT expected,
                              input logic checkLatency);
    int cycles;
    @(posedge clk);
    inReq.plainText <= plain;
    inReq.cipherKey <= key;
    inValid <= 1'b1;
    waitAccept();
    inValid <= 1'b0;
    waitResult(cycles);
    if (checkLatency)
      checkValue("latency", 128'(NumRounds), 128'(cycles));
    checkValue("outData", expected, outData);
    // outReady is high, so the next edge consumes
    @(posedge clk);
    @(negedge clk);
    checkValue("outValid", 128'd0, 128'(outValid));
    checkValue("inReady", 128'd1, 128'(inReady));
  endtask

  task automatic testBackPressure(input stateT plain, input stateT key, input stateT expected);
    int cycles;
    int i;
    @(posedge clk);
    outReady <= 1'b0;
    inReq.plainText <= plain;
    inReq.cipherKey <= key;
    inValid <= 1'b1;
    waitAccept();
    inValid <= 1'b0;
    waitResult(cycles);
    checkValue("latency", 128'(NumRounds), 128'(cycles));
    checkValue("outData", expected, outData);
    // A new request is offered while the result is held
    @(posedge clk);
    inValid <= 1'b1;
    for (i = 0; i < HoldCycles; i++)
    begin
      @(negedge clk);
      checkValue("outValid", 128'd1, 128'(outValid));
      checkValue("outData", expected, outData);
      checkValue("inReady", 128'd0, 128'(inReady));
      @(posedge clk);
    end
    outReady <= 1'b1;
    inValid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkValue("outValid", 128'd0, 128'(outValid));
    checkValue("inReady", 128'd1, 128'(inReady));
  endtask

  task automatic testBackToBack(input stateT plain0, input stateT key0, input stateT expected0,
                                input stateT plain1, input stateT key1, input stateT expected1);
    int cycles;
    @(posedge clk);
    inReq.plainText <= plain0;
    inReq.cipherKey <= key0;
    inValid <= 1'b1;
    waitAccept();
    // Second request waits on the port with inValid still high
    inReq.plainText <= plain1;
    inReq.cipherKey <= key1;
    waitResult(cycles);
    checkValue("latency", 128'(NumRounds), 128'(cycles));
    checkValue("outData", expected0, outData);
    waitAccept();
    inValid <= 1'b0;
    waitResult(cycles);
    checkValue("latency", 128'(NumRounds), 128'(cycles));
    checkValue("outData", expected1, outData);
    @(posedge clk);
    @(negedge clk);
    checkValue("outValid", 128'd0, 128'(outValid));
    checkValue("inReady", 128'd1, 128'(inReady));
  endtask

  initial
  begin
    rstN = 1'b0;
    inValid = 1'b0;
    inReq = '0;
    outReady = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    outReady <= 1'b1;

    testReset();
    encryptBlock(PlainB, KeyB, CipherB, 1'b0);
    encryptBlock(PlainC1, KeyC1, CipherC1, 1'b1);
    encryptBlock('0, '0, CipherZero, 1'b0);
    testBackPressure(PlainB, KeyB, CipherB);
    testBackToBack(PlainB, KeyB, CipherB, PlainC1, KeyC1, CipherC1);

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial
  begin
    #(TimeoutNs);
    $display("Error at %0t ns: simulation timed out before the tests finished", $time);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: aesCore.f
verilog/aesPkg.sv
verilog/aesSbox.sv
verilog/aesMixColumns.sv
verilog/aesRound.sv
verilog/aesKeyExpand.sv
verilog/aesCore.sv
testbench/tbClock.sv
testbench/tbAesCore.sv

// File: run.sh
#!/bin/sh
# Build and run the AES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -f aesCore.f --top-module tbAesCore -o VtbAesCore
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtbAesCore > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi
